/* dist.f */
+incdir+.
dist_pkg.sv
distribute_1x2_seq.sv
dist_mask_decode.sv
dist_tree.sv
dist_leaf_collect.sv
dist_top.sv
dist_tb.sv

/* Makefile */
# Verilator build and run for the distribution network testbench

VERILATOR := verilator
TOP       := dist_tb
FILELIST  := dist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dist_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module dist_tb;

    import dist_pkg::*;

    localparam int RESET_CYCLES  = 10;
    localparam int LATENCY       = 4;
    localparam int DRAIN_LIMIT   = 200;
    localparam int STREAM_CYCLES = 300;

    // dut side
    logic       clk;
    logic       i_rst_n;
    logic       i_en;
    logic       i_valid;
    data_t      i_data;
    leaf_mask_t i_mask;
    logic [3:0] o_leaf_valid;
    data_t      o_leaf_data [3:0];
    count_t     o_leaf_count [3:0];

    // per-leaf scoreboard rings
    // written at negedge and read at posedge
    data_t      sb_mem [4][0:255];
    logic [7:0] sb_wr [4];
    logic [7:0] sb_rd [4];
    count_t     exp_count [4];

    logic [15:0] lfsr_state;
    string       test_name;
    logic        prev_en;

    // masks that fan out to more than one leaf
    leaf_mask_t  dup_masks [4] = '{4'b0011, 4'b1100, 4'b0101, 4'b1111};

    dist_top dut (
        .i_clk        (clk),
        .i_rst_n      (i_rst_n),
        .i_en         (i_en),
        .i_valid      (i_valid),
        .i_data       (i_data),
        .i_mask       (i_mask),
        .o_leaf_valid (o_leaf_valid),
        .o_leaf_data  (o_leaf_data),
        .o_leaf_count (o_leaf_count)
    );

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus source and reference
    ////////////////////////////////////////////////////////////

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // leaf k gets the word when it is valid and mask bit k is set
    function automatic leaf_mask_t expected_leaves(input logic valid, input leaf_mask_t mask);
        leaf_mask_t sel;
        sel = '0;
        for (int k = 0; k < 4; k++)
            sel[k] = valid && mask[k];
        return sel;
    endfunction

    function automatic logic scoreboard_empty();
        logic empty;
        empty = 1'b1;
        for (int k = 0; k < 4; k++)
            if (sb_wr[k] != sb_rd[k])
                empty = 1'b0;
        return empty;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic stop_on_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (exp !== act)
        begin
            $display("error: %s %s expected %h actual %h", test_name, what, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string what, input count_t exp, input count_t act);
        if (exp !== act)
        begin
            $display("error: %s %s expected %0d actual %0d", test_name, what, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_valid(input string what, input leaf_mask_t exp, input leaf_mask_t act);
        if (exp !== act)
        begin
            $display("error: %s %s expected %b actual %b", test_name, what, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_counts();
        for (int k = 0; k < 4; k++)
            check_count($sformatf("leaf %0d count", k), exp_count[k], o_leaf_count[k]);
    endtask

    // pops the head of each leaf that reports a word
    always @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            prev_en = 1'b1;
            for (int k = 0; k < 4; k++)
                sb_rd[k] = '0;
        end
        else
        begin
            // an edge with i_en low must leave every strobe low
            if (!prev_en)
                check_valid("valid after stalled edge", '0, o_leaf_valid);
            for (int k = 0; k < 4; k++)
            begin
                if (o_leaf_valid[k] && (sb_wr[k] == sb_rd[k]))
                begin
                    $display("%s: leaf %0d delivered a word that was never sent", test_name, k);
                    stop_on_failure();
                end
                else if (o_leaf_valid[k])
                begin
                    check_data($sformatf("leaf %0d data", k), sb_mem[k][sb_rd[k]],
                               o_leaf_data[k]);
                    sb_rd[k] = sb_rd[k] + 8'd1;
                end
            end
            prev_en = i_en;
        end
    end

    ////////////////////////////////////////////////////////////
    // drivers
    ////////////////////////////////////////////////////////////

    // pushes the word to every leaf it must reach
    task automatic record_word(input logic valid, input leaf_mask_t mask, input data_t d);
        leaf_mask_t sel;
        sel = expected_leaves(valid, mask);
        for (int k = 0; k < 4; k++)
        begin
            if (sel[k])
            begin
                sb_mem[k][sb_wr[k]] = d;
                sb_wr[k] = sb_wr[k] + 8'd1;
                exp_count[k] = exp_count[k] + count_t'(1);
            end
        end
    endtask

    // falling edge drive
    // the word only counts when en is high
    task automatic drive(input logic en, input logic valid, input leaf_mask_t mask,
                         input data_t d);
        @(negedge clk);
        i_en    = en;
        i_valid = valid;
        i_mask  = mask;
        i_data  = d;
        if (en)
            record_word(valid, mask, d);
    endtask

    task automatic drain();
        int cyc;
        cyc = 0;
        while (!scoreboard_empty() && (cyc < DRAIN_LIMIT))
        begin
            drive(1'b1, 1'b0, '0, '0);
            cyc++;
        end
        if (!scoreboard_empty())
        begin
            $display("%s: words still missing after %0d idle cycles", test_name, DRAIN_LIMIT);
            stop_on_failure();
        end
        // idle tail to catch late extra deliveries
        repeat (LATENCY + 2)
            drive(1'b1, 1'b0, '0, '0);
    endtask

    // one word with strobes checked on each of the next four edges
    task automatic send_and_watch(input logic valid, input leaf_mask_t mask, input data_t d);
        leaf_mask_t exp;
        drive(1'b1, valid, mask, d);
        for (int n = 1; n <= LATENCY; n++)
        begin
            drive(1'b1, 1'b0, '0, '0);
            exp = (n == LATENCY) ? expected_leaves(valid, mask) : leaf_mask_t'(0);
            check_valid($sformatf("valid after %0d edges", n), exp, o_leaf_valid);
        end
        drain();
        check_counts();
    endtask

    initial
    begin
        lfsr_state = 16'd39;
        test_name  = "reset";
        i_rst_n    = 1'b0;
        i_en       = 1'b1;
        i_valid    = 1'b0;
        i_mask     = '0;
        i_data     = '0;
        for (int k = 0; k < 4; k++)
        begin
            sb_wr[k]     = '0;
            exp_count[k] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        check_valid("leaf valid", '0, o_leaf_valid);
        check_counts();
        for (int k = 0; k < 4; k++)
            check_data($sformatf("leaf %0d data", k), '0, o_leaf_data[k]);

        test_name = "single leaf";
        for (int k = 0; k < 4; k++)
            send_and_watch(1'b1, leaf_mask_t'(1 << k), data_t'(take_bits(32)));

        test_name = "duplicate and broadcast";
        for (int m = 0; m < 4; m++)
            send_and_watch(1'b1, dup_masks[m], data_t'(take_bits(32)));

        // invalid words and empty masks
        test_name = "drop rule";
        send_and_watch(1'b0, 4'b1111, data_t'(take_bits(32)));
        send_and_watch(1'b0, 4'b0110, data_t'(take_bits(32)));
        send_and_watch(1'b1, 4'b0000, data_t'(take_bits(32)));

        // en low on about a quarter of the edges
        test_name = "stall stream";
        for (int i = 0; i < STREAM_CYCLES; i++)
            drive(take_bits(2) != 32'd0, take_bits(1) != 32'd0,
                  leaf_mask_t'(take_bits(4)), data_t'(take_bits(32)));
        drain();

        test_name = "counters";
        check_counts();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* dist_top.sv */
`default_nettype none
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// 1-to-4 distribution network
////////////////////////////////////////////////////////////

// decode -> root -> leaf nodes -> collect
// four enabled edges from input to leaf output

module dist_top (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_en,
    input  logic                 i_valid,
    input  dist_pkg::data_t      i_data,
    input  dist_pkg::leaf_mask_t i_mask,
    output logic [3:0]           o_leaf_valid,
    output dist_pkg::data_t      o_leaf_data [3:0],
    output dist_pkg::count_t     o_leaf_count [3:0]
);

    import dist_pkg::*;

    // decode stage outputs
    logic  dec_valid;
    data_t dec_data;
    cmd_t  dec_root_cmd;
    cmd_t  dec_low_cmd;
    cmd_t  dec_high_cmd;

    // tree leaves, before the output register
    logic [3:0] tree_leaf_valid;
    data_t      tree_leaf_data [3:0];

    // mask to per-node commands
    dist_mask_decode u_decode (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_en       (i_en),
        .i_valid    (i_valid),
        .i_data     (i_data),
        .i_mask     (i_mask),
        .o_valid    (dec_valid),
        .o_data     (dec_data),
        .o_root_cmd (dec_root_cmd),
        .o_low_cmd  (dec_low_cmd),
        .o_high_cmd (dec_high_cmd)
    );

    // node tree
    dist_tree u_tree (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_en         (i_en),
        .i_valid      (dec_valid),
        .i_data       (dec_data),
        .i_root_cmd   (dec_root_cmd),
        .i_low_cmd    (dec_low_cmd),
        .i_high_cmd   (dec_high_cmd),
        .o_leaf_valid (tree_leaf_valid),
        .o_leaf_data  (tree_leaf_data)
    );

    // output register and counters
    dist_leaf_collect u_collect (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_en         (i_en),
        .i_leaf_valid (tree_leaf_valid),
        .i_leaf_data  (tree_leaf_data),
        .o_leaf_valid (o_leaf_valid),
        .o_leaf_data  (o_leaf_data),
        .o_leaf_count (o_leaf_count)
    );

endmodule

`default_nettype wire

/* dist_leaf_collect.sv */
`default_nettype none
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// leaf output register and delivery counters
////////////////////////////////////////////////////////////

module dist_leaf_collect (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_en,
    input  logic [3:0]       i_leaf_valid,
    input  dist_pkg::data_t  i_leaf_data [3:0],
    output logic [3:0]       o_leaf_valid,
    output dist_pkg::data_t  o_leaf_data [3:0],
    output dist_pkg::count_t o_leaf_count [3:0]
);

    import dist_pkg::*;

    // valid strobe
    // dropped during a stall so a held word shows up once
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_leaf_valid <= '0;
        end
        else if (i_en)
        begin
            o_leaf_valid <= i_leaf_valid;
        end
        else
        begin
            o_leaf_valid <= '0;
        end
    end

    // leaf words, held while disabled
    always_ff @(posedge i_clk)
    begin
        for (int k = 0; k < 4; k++)
        begin
            if (!i_rst_n)
                o_leaf_data[k] <= '0;
            else if (i_en)
                o_leaf_data[k] <= i_leaf_data[k];
        end
    end

    ////////////////////////////////////////////////////////////
    // delivery counters
    ////////////////////////////////////////////////////////////

    // one count per delivered word, wraps at full scale
    always_ff @(posedge i_clk)
    begin
        for (int k = 0; k < 4; k++)
        begin
            if (!i_rst_n)
                o_leaf_count[k] <= '0;
            else if (i_en && i_leaf_valid[k])
                o_leaf_count[k] <= o_leaf_count[k] + count_t'(1);
        end
    end

    // a count moves only on an enabled edge that delivered to that leaf
    for (genvar k = 0; k < 4; k++)
    begin : g_count_chk
        a_count_step: assert property (
            @(posedge i_clk) disable iff (!i_rst_n)
            (o_leaf_count[k] != $past(o_leaf_count[k])) |->
                $past(i_en && i_leaf_valid[k])
        );
    end

endmodule

`default_nettype wire

/* dist_tree.sv */
`default_nettype none
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// two level distribute tree
////////////////////////////////////////////////////////////

//                 root
//               /      \
//          low node    high node
//          /    \       /    \
//      leaf0  leaf1  leaf2  leaf3

module dist_tree (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_en,
    input  logic            i_valid,
    input  dist_pkg::data_t i_data,
    input  dist_pkg::cmd_t  i_root_cmd,
    input  dist_pkg::cmd_t  i_low_cmd,
    input  dist_pkg::cmd_t  i_high_cmd,
    output logic [3:0]      o_leaf_valid,
    output dist_pkg::data_t o_leaf_data [3:0]
);

    import dist_pkg::*;

    // root outputs, [1] high branch, [0] low branch
    logic [1:0]  root_valid;
    data_t [1:0] root_data;

    // second level commands, one stage behind
    cmd_t low_cmd_q;
    cmd_t high_cmd_q;

    // leaf node outputs
    logic [1:0]  low_valid;
    data_t [1:0] low_data;
    logic [1:0]  high_valid;
    data_t [1:0] high_data;

    // leaf commands wait one enabled edge
    // so they meet the word leaving the root
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            low_cmd_q  <= CMD_NONE;
            high_cmd_q <= CMD_NONE;
        end
        else if (i_en)
        begin
            low_cmd_q  <= i_low_cmd;
            high_cmd_q <= i_high_cmd;
        end
    end

    ////////////////////////////////////////////////////////////
    // nodes
    ////////////////////////////////////////////////////////////

    distribute_1x2_seq u_root (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_en       (i_en),
        .i_valid    (i_valid),
        .i_data_bus (i_data),
        .i_cmd      (i_root_cmd),
        .o_valid    (root_valid),
        .o_data_bus (root_data)
    );

    // low branch of root serves leaves 0 and 1
    distribute_1x2_seq u_low (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_en       (i_en),
        .i_valid    (root_valid[0]),
        .i_data_bus (root_data[0]),
        .i_cmd      (low_cmd_q),
        .o_valid    (low_valid),
        .o_data_bus (low_data)
    );

    // high branch of root serves leaves 2 and 3
    distribute_1x2_seq u_high (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_en       (i_en),
        .i_valid    (root_valid[1]),
        .i_data_bus (root_data[1]),
        .i_cmd      (high_cmd_q),
        .o_valid    (high_valid),
        .o_data_bus (high_data)
    );

    // flatten leaf outputs in leaf order
    assign o_leaf_valid = {high_valid, low_valid};

    for (genvar k = 0; k < 2; k++)
    begin : g_leaf
        assign o_leaf_data[k]     = low_data[k];
        assign o_leaf_data[k + 2] = high_data[k];
    end

endmodule

`default_nettype wire

/* dist_mask_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module dist_mask_decode (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_en,
    input  logic                i_valid,
    input  dist_pkg::data_t     i_data,
    input  dist_pkg::leaf_mask_t i_mask,
    output logic                o_valid,
    output dist_pkg::data_t     o_data,
    output dist_pkg::cmd_t      o_root_cmd,
    output dist_pkg::cmd_t      o_low_cmd,
    output dist_pkg::cmd_t      o_high_cmd
);

    import dist_pkg::*;

    // next-state commands
    cmd_t root_cmd_d;
    cmd_t low_cmd_d;
    cmd_t high_cmd_d;
    logic take;

    // zero mask counts as nothing to send
    assign take = i_valid && (i_mask != '0);

    // root sends low if either leaf 0 or 1 wants it
    // and high if either leaf 2 or 3 wants it
    assign root_cmd_d = take ? {|i_mask[3:2], |i_mask[1:0]} : CMD_NONE;
    // second level commands are the raw mask pairs
    assign low_cmd_d  = take ? i_mask[1:0] : CMD_NONE;
    assign high_cmd_d = take ? i_mask[3:2] : CMD_NONE;

    ////////////////////////////////////////////////////////////
    // decode register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_valid    <= 1'b0;
            o_data     <= '0;
            o_root_cmd <= CMD_NONE;
            o_low_cmd  <= CMD_NONE;
            o_high_cmd <= CMD_NONE;
        end
        else if (i_en)
        begin
            o_valid    <= take;
            o_data     <= i_data;
            o_root_cmd <= root_cmd_d;
            o_low_cmd  <= low_cmd_d;
            o_high_cmd <= high_cmd_d;
        end
    end

    // no stray command may reach the tree with an empty slot
    a_cmd_needs_valid: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        ((o_root_cmd != CMD_NONE) || (o_low_cmd != CMD_NONE) ||
         (o_high_cmd != CMD_NONE)) |-> o_valid
    );

endmodule

`default_nettype wire

/* distribute_1x2_seq.sv */
`default_nettype none
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// registered 1x2 distribute node
////////////////////////////////////////////////////////////

// cmd 00 drops the word
// cmd 01 sends it low, cmd 10 sends it high
// cmd 11 duplicates it to both branches
// o_data_bus[1] is the high branch, o_data_bus[0] the low one

module distribute_1x2_seq (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_en,
    input  logic                  i_valid,
    input  dist_pkg::data_t       i_data_bus,
    input  dist_pkg::cmd_t        i_cmd,
    output logic [1:0]            o_valid,
    output dist_pkg::data_t [1:0] o_data_bus
);

    import dist_pkg::*;

    // branch select after gating with input valid
    cmd_t fwd;

    // an invalid word never opens a branch
    assign fwd = i_valid ? i_cmd : CMD_NONE;

    ////////////////////////////////////////////////////////////
    // branch registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_valid    <= '0;
            o_data_bus <= '0;
        end
        else if (i_en)
        begin
            for (int b = 0; b < 2; b++)
            begin
                if (fwd[b])
                begin
                    o_valid[b]    <= 1'b1;
                    o_data_bus[b] <= i_data_bus;
                end
                else
                begin
                    // unselected branch carries the dummy word
                    o_valid[b]    <= 1'b0;
                    o_data_bus[b] <= '0;
                end
            end
        end
        // disabled, both branches hold
    end

    // each branch valid only rises from a request one enabled edge back
    for (genvar b = 0; b < 2; b++)
    begin : g_branch_chk
        a_rise_has_cause: assert property (
            @(posedge i_clk) disable iff (!i_rst_n)
            $rose(o_valid[b]) |-> $past(i_en && i_valid && i_cmd[b])
        );
    end

endmodule

`default_nettype wire

/* dist_pkg.sv */
`default_nettype none

`include "dist_settings.svh"

package dist_pkg;

    ////////////////////////////////////////////////////////////
    // payload and bookkeeping widths
    ////////////////////////////////////////////////////////////

    // one payload word
    typedef logic [`DIST_DATA_WIDTH-1:0] data_t;

    // destination mask, bit k selects leaf k
    typedef logic [3:0] leaf_mask_t;

    // delivery counter per leaf
    typedef logic [`DIST_COUNT_WIDTH-1:0] count_t;

    ////////////////////////////////////////////////////////////
    // node commands
    ////////////////////////////////////////////////////////////

    // bit 0 feeds the low branch, bit 1 the high branch
    typedef logic [1:0] cmd_t;

    localparam cmd_t CMD_NONE = 2'b00;
    localparam cmd_t CMD_LOW  = 2'b01;
    localparam cmd_t CMD_HIGH = 2'b10;
    localparam cmd_t CMD_DUP  = 2'b11;

endpackage

`default_nettype wire

/* dist_settings.svh */
`ifndef DIST_SETTINGS_SVH
`define DIST_SETTINGS_SVH

////////////////////////////////////////////////////////////
// distribution network sizing
////////////////////////////////////////////////////////////

// payload word carried through every node
`define DIST_DATA_WIDTH 32

// per-leaf delivery counter
// wraps at full scale
`define DIST_COUNT_WIDTH 16

// leaf count is not a knob here
// two levels of 1x2 nodes give four leaves
// growing the tree means a new tree module

`endif
